// ==== src/sys_pkg.sv ====
`default_nettype none

package sys_pkg;

    // memory geometry
    localparam int RAM_WORDS = 1024;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);

    // command queue of each master
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // data word, also used for byte addresses
    typedef logic [31:0] word_t;

    // one enable per byte lane
    typedef logic [3:0] mask_t;

    // copy length in words, 0 to RAM_WORDS
    typedef logic [10:0] len_t;

    // single host access
    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
        mask_t mask;
    } host_cmd_t;

    // block copy descriptor
    typedef struct packed {
        word_t src;
        word_t dst;
        len_t  len;
    } copy_desc_t;

endpackage

`default_nettype wire

// ==== src/system_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module system_ram (
    input  wire logic           clk_i,
    input  wire logic           cs_i,
    input  wire sys_pkg::word_t addr_i,
    input  wire sys_pkg::word_t wdata_i,
    input  wire sys_pkg::mask_t mask_i,
    output sys_pkg::word_t      rdata_o
);
    import sys_pkg::*;

    // word array, starts cleared in simulation
    word_t mem_r [0:RAM_WORDS-1] = '{default: '0};
    word_t rdata_r = '0;

    logic [RAM_IDX_W-1:0] idx;

    // byte address to word index
    assign idx = addr_i[RAM_IDX_W+1:2];

    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            // read-first, a write returns the old word
            rdata_r <= mem_r[idx];

            for (int b = 0; b < $bits(mask_t); b++) begin
                if (mask_i[b]) begin
                    mem_r[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = rdata_r;

endmodule

`default_nettype wire

// ==== src/cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
    parameter type item_t = logic
) (
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    input  wire logic  push_i,
    input  wire item_t push_data_i,
    input  wire logic  pop_i,
    output item_t      head_o,
    output logic       empty_o,
    output logic       full_o
);
    import sys_pkg::*;

    item_t slot_r [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr_r;
    logic [FIFO_PTR_W-1:0] rd_ptr_r;
    logic [FIFO_CNT_W-1:0] count_r;

    assign head_o  = slot_r[rd_ptr_r];
    assign empty_o = (count_r == '0);
    assign full_o  = (count_r == FIFO_CNT_W'(FIFO_DEPTH));

    // storage, no reset needed
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            slot_r[wr_ptr_r] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_r <= (wr_ptr_r == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_r <= (rd_ptr_r == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
            end
            if (push_i && !pop_i) begin
                count_r <= count_r + 1'b1;
            end else if (pop_i && !push_i) begin
                count_r <= count_r - 1'b1;
            end
        end
    end

    // sender keeps at most FIFO_DEPTH commands outstanding
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> !full_o);

    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire logic           clk_i,
    input  wire logic           rst_i,
    // host master
    input  wire logic           h_req_i,
    input  wire logic           h_we_i,
    input  wire sys_pkg::word_t h_addr_i,
    input  wire sys_pkg::word_t h_wdata_i,
    input  wire sys_pkg::mask_t h_mask_i,
    output logic                h_gnt_o,
    output logic                h_rvalid_o,
    // copy master
    input  wire logic           c_req_i,
    input  wire logic           c_we_i,
    input  wire sys_pkg::word_t c_addr_i,
    input  wire sys_pkg::word_t c_wdata_i,
    input  wire sys_pkg::mask_t c_mask_i,
    output logic                c_gnt_o,
    output logic                c_rvalid_o,
    output sys_pkg::word_t      rdata_o,
    // RAM side
    output logic                ram_cs_o,
    output sys_pkg::word_t      ram_addr_o,
    output sys_pkg::word_t      ram_wdata_o,
    output sys_pkg::mask_t      ram_mask_o,
    input  wire sys_pkg::word_t ram_rdata_i
);

    // set when the copy master was served last
    logic last_c_r;
    // read in the RAM pipeline and its owner
    logic rd_pend_r;
    logic rd_own_c_r;

    // lone requester wins, otherwise the one not served last
    assign h_gnt_o = h_req_i && (!c_req_i || last_c_r);
    assign c_gnt_o = c_req_i && (!h_req_i || !last_c_r);

    assign ram_cs_o    = h_gnt_o || c_gnt_o;
    assign ram_addr_o  = c_gnt_o ? c_addr_i : h_addr_i;
    assign ram_wdata_o = c_gnt_o ? c_wdata_i : h_wdata_i;
    // reads go out with an empty mask
    assign ram_mask_o  = c_gnt_o ? (c_we_i ? c_mask_i : '0) : (h_we_i ? h_mask_i : '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_c_r   <= 1'b0;
            rd_pend_r  <= 1'b0;
            rd_own_c_r <= 1'b0;
        end else begin
            if (ram_cs_o) begin
                last_c_r <= c_gnt_o;
            end
            rd_pend_r  <= (h_gnt_o && !h_we_i) || (c_gnt_o && !c_we_i);
            rd_own_c_r <= c_gnt_o;
        end
    end

    assign h_rvalid_o = rd_pend_r && !rd_own_c_r;
    assign c_rvalid_o = rd_pend_r && rd_own_c_r;
    assign rdata_o    = ram_rdata_i;

    a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        !(h_gnt_o && c_gnt_o));

    // masters hold a waiting request steady
    a_h_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        h_req_i && !h_gnt_o |=> h_req_i && $stable(h_we_i) && $stable(h_addr_i)
            && $stable(h_wdata_i));

    a_c_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        c_req_i && !c_gnt_o |=> c_req_i && $stable(c_we_i) && $stable(c_addr_i)
            && $stable(c_wdata_i));

endmodule

`default_nettype wire

// ==== src/host_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_port (
    input  wire logic           clk_i,
    input  wire logic           rst_i,
    // outside
    input  wire logic           host_stb_i,
    input  wire logic           host_we_i,
    input  wire sys_pkg::word_t host_addr_i,
    input  wire sys_pkg::word_t host_wdata_i,
    input  wire sys_pkg::mask_t host_mask_i,
    output sys_pkg::word_t      host_rdata_o,
    output logic                host_rvalid_o,
    // toward the arbiter
    output logic                bus_req_o,
    output logic                bus_we_o,
    output sys_pkg::word_t      bus_addr_o,
    output sys_pkg::word_t      bus_wdata_o,
    output sys_pkg::mask_t      bus_mask_o,
    input  wire logic           bus_gnt_i,
    input  wire logic           bus_rvalid_i,
    input  wire sys_pkg::word_t bus_rdata_i
);
    import sys_pkg::*;

    host_cmd_t push_cmd;
    host_cmd_t head_cmd;
    logic      fifo_empty;
    // read granted, data not back yet
    logic      rd_wait_r;

    assign push_cmd.we    = host_we_i;
    assign push_cmd.addr  = host_addr_i;
    assign push_cmd.wdata = host_wdata_i;
    assign push_cmd.mask  = host_mask_i;

    cmd_fifo #(
        .item_t(host_cmd_t)
    ) i_cmd_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .push_i     (host_stb_i),
        .push_data_i(push_cmd),
        .pop_i      (bus_gnt_i),
        .head_o     (head_cmd),
        .empty_o    (fifo_empty),
        .full_o     ()
    );

    // head command goes out, popped on grant
    assign bus_req_o   = !fifo_empty && !rd_wait_r;
    assign bus_we_o    = head_cmd.we;
    assign bus_addr_o  = head_cmd.addr;
    assign bus_wdata_o = head_cmd.wdata;
    assign bus_mask_o  = head_cmd.mask;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_wait_r     <= 1'b0;
            host_rvalid_o <= 1'b0;
        end else begin
            if (bus_gnt_i && !head_cmd.we) begin
                rd_wait_r <= 1'b1;
            end else if (bus_rvalid_i) begin
                rd_wait_r <= 1'b0;
            end
            host_rvalid_o <= bus_rvalid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_rvalid_i) begin
            host_rdata_o <= bus_rdata_i;
        end
    end

    // read data only comes back for a read we issued
    a_rvalid_owned: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_rvalid_i |-> rd_wait_r);

endmodule

`default_nettype wire

// ==== src/copy_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module copy_engine (
    input  wire logic           clk_i,
    input  wire logic           rst_i,
    // outside
    input  wire logic           copy_stb_i,
    input  wire sys_pkg::word_t copy_src_i,
    input  wire sys_pkg::word_t copy_dst_i,
    input  wire sys_pkg::len_t  copy_len_i,
    output logic                copy_done_o,
    // toward the arbiter
    output logic                bus_req_o,
    output logic                bus_we_o,
    output sys_pkg::word_t      bus_addr_o,
    output sys_pkg::word_t      bus_wdata_o,
    output sys_pkg::mask_t      bus_mask_o,
    input  wire logic           bus_gnt_i,
    input  wire logic           bus_rvalid_i,
    input  wire sys_pkg::word_t bus_rdata_i
);
    import sys_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WAIT,
        ST_WRITE
    } state_t;

    copy_desc_t push_desc;
    copy_desc_t head_desc;
    logic       fifo_empty;
    logic       fifo_pop;
    state_t     state_r;

    // working copy of the head descriptor
    word_t src_r;
    word_t dst_r;
    len_t  left_r;
    word_t data_r;

    assign push_desc.src = copy_src_i;
    assign push_desc.dst = copy_dst_i;
    assign push_desc.len = copy_len_i;

    cmd_fifo #(
        .item_t(copy_desc_t)
    ) i_desc_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .push_i     (copy_stb_i),
        .push_data_i(push_desc),
        .pop_i      (fifo_pop),
        .head_o     (head_desc),
        .empty_o    (fifo_empty),
        .full_o     ()
    );

    // descriptor retires once no words are left
    assign fifo_pop = (state_r == ST_READ) && (left_r == '0);

    assign bus_req_o   = ((state_r == ST_READ) && (left_r != '0)) || (state_r == ST_WRITE);
    assign bus_we_o    = (state_r == ST_WRITE);
    assign bus_addr_o  = (state_r == ST_WRITE) ? dst_r : src_r;
    assign bus_wdata_o = data_r;
    assign bus_mask_o  = '1;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_r     <= ST_IDLE;
            copy_done_o <= 1'b0;
        end else begin
            copy_done_o <= fifo_pop;
            case (state_r)
                ST_IDLE: begin
                    if (!fifo_empty) begin
                        state_r <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (fifo_pop) begin
                        state_r <= ST_IDLE;
                    end else if (bus_gnt_i) begin
                        state_r <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (bus_rvalid_i) begin
                        state_r <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (bus_gnt_i) begin
                        state_r <= ST_READ;
                    end
                end
                default: state_r <= ST_IDLE;
            endcase
        end
    end

    // pointers, count and data word
    always_ff @(posedge clk_i) begin
        case (state_r)
            ST_IDLE: begin
                src_r  <= head_desc.src;
                dst_r  <= head_desc.dst;
                left_r <= head_desc.len;
            end
            ST_WAIT: begin
                if (bus_rvalid_i) begin
                    data_r <= bus_rdata_i;
                end
            end
            ST_WRITE: begin
                if (bus_gnt_i) begin
                    src_r  <= src_r + 32'd4;
                    dst_r  <= dst_r + 32'd4;
                    left_r <= left_r - 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    // read data lands exactly in the wait state
    a_rvalid_in_wait: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_rvalid_i == (state_r == ST_WAIT));

endmodule

`default_nettype wire

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  wire logic           clk_i,
    input  wire logic           rst_i,
    // host access port
    input  wire logic           host_stb_i,
    input  wire logic           host_we_i,
    input  wire sys_pkg::word_t host_addr_i,
    input  wire sys_pkg::word_t host_wdata_i,
    input  wire sys_pkg::mask_t host_mask_i,
    output sys_pkg::word_t      host_rdata_o,
    output logic                host_rvalid_o,
    // copy port
    input  wire logic           copy_stb_i,
    input  wire sys_pkg::word_t copy_src_i,
    input  wire sys_pkg::word_t copy_dst_i,
    input  wire sys_pkg::len_t  copy_len_i,
    output logic                copy_done_o
);
    import sys_pkg::*;

    // host master bus
    logic  h_req, h_we, h_gnt, h_rvalid;
    word_t h_addr, h_wdata;
    mask_t h_mask;

    // copy master bus
    logic  c_req, c_we, c_gnt, c_rvalid;
    word_t c_addr, c_wdata;
    mask_t c_mask;

    // shared read data and RAM port
    word_t bus_rdata;
    logic  ram_cs;
    word_t ram_addr, ram_wdata, ram_rdata;
    mask_t ram_mask;

    host_port i_host_port (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .host_stb_i   (host_stb_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_mask_i  (host_mask_i),
        .host_rdata_o (host_rdata_o),
        .host_rvalid_o(host_rvalid_o),
        .bus_req_o    (h_req),
        .bus_we_o     (h_we),
        .bus_addr_o   (h_addr),
        .bus_wdata_o  (h_wdata),
        .bus_mask_o   (h_mask),
        .bus_gnt_i    (h_gnt),
        .bus_rvalid_i (h_rvalid),
        .bus_rdata_i  (bus_rdata)
    );

    copy_engine i_copy_engine (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .copy_stb_i  (copy_stb_i),
        .copy_src_i  (copy_src_i),
        .copy_dst_i  (copy_dst_i),
        .copy_len_i  (copy_len_i),
        .copy_done_o (copy_done_o),
        .bus_req_o   (c_req),
        .bus_we_o    (c_we),
        .bus_addr_o  (c_addr),
        .bus_wdata_o (c_wdata),
        .bus_mask_o  (c_mask),
        .bus_gnt_i   (c_gnt),
        .bus_rvalid_i(c_rvalid),
        .bus_rdata_i (bus_rdata)
    );

    bus_arbiter i_bus_arbiter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .h_req_i    (h_req),
        .h_we_i     (h_we),
        .h_addr_i   (h_addr),
        .h_wdata_i  (h_wdata),
        .h_mask_i   (h_mask),
        .h_gnt_o    (h_gnt),
        .h_rvalid_o (h_rvalid),
        .c_req_i    (c_req),
        .c_we_i     (c_we),
        .c_addr_i   (c_addr),
        .c_wdata_i  (c_wdata),
        .c_mask_i   (c_mask),
        .c_gnt_o    (c_gnt),
        .c_rvalid_o (c_rvalid),
        .rdata_o    (bus_rdata),
        .ram_cs_o   (ram_cs),
        .ram_addr_o (ram_addr),
        .ram_wdata_o(ram_wdata),
        .ram_mask_o (ram_mask),
        .ram_rdata_i(ram_rdata)
    );

    system_ram i_system_ram (
        .clk_i  (clk_i),
        .cs_i   (ram_cs),
        .addr_i (ram_addr),
        .wdata_i(ram_wdata),
        .mask_i (ram_mask),
        .rdata_o(ram_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic clk_o
);

    // free running, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;
    import sys_pkg::*;

    localparam int N_RAND   = 8;
    localparam int MAX_LEN4 = 32;
    localparam int MAX_LEN5 = 48;
    localparam int N_ZERO   = 8;
    // host accesses over all tests, doubled to cover the fence reads
    localparam int HOST_OPS = 2 * (4 * N_RAND + 4 + 3 * MAX_LEN4 + 2 * N_RAND + MAX_LEN5 + N_ZERO);
    localparam int COPY_WORDS  = MAX_LEN4 + MAX_LEN5;
    localparam int CYCLE_LIMIT = 20 * HOST_OPS + 5 * COPY_WORDS + 200;
    localparam int WAIT_LIMIT  = 1000;

    logic  clk;
    logic  rst_i;
    logic  host_stb;
    logic  host_we;
    word_t host_addr;
    word_t host_wdata;
    mask_t host_mask;
    word_t host_rdata;
    logic  host_rvalid;
    logic  copy_stb;
    word_t copy_src;
    word_t copy_dst;
    len_t  copy_len;
    logic  copy_done;

    // reference memory, RAM starts cleared
    word_t model_mem [RAM_WORDS];
    word_t exp_q [$];
    string exp_name_q [$];

    integer seed;
    int     read_checks = 0;
    int     read_errors = 0;
    int     main_checks = 0;
    int     main_errors = 0;
    int     done_count = 0;
    int     copies_issued = 0;
    int     cycles = 0;
    int     host_batch = 0;
    int     last_idx = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     errs_at_start = 0;
    string  cur_test;

    tb_clock #(
        .PERIOD_NS(10)
    ) i_tb_clock (
        .clk_o(clk)
    );

    mem_subsystem i_mem_subsystem (
        .clk_i        (clk),
        .rst_i        (rst_i),
        .host_stb_i   (host_stb),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_mask_i  (host_mask),
        .host_rdata_o (host_rdata),
        .host_rvalid_o(host_rvalid),
        .copy_stb_i   (copy_stb),
        .copy_src_i   (copy_src),
        .copy_dst_i   (copy_dst),
        .copy_len_i   (copy_len),
        .copy_done_o  (copy_done)
    );

    // byte lanes with a set mask bit take the new data
    function automatic word_t masked_write(input word_t old_word, input word_t new_word,
                                           input mask_t mask);
        word_t res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    // word by word, lowest address first
    function automatic void ref_copy(input int src_idx, input int dst_idx, input int len);
        for (int i = 0; i < len; i++) begin
            model_mem[(dst_idx + i) % RAM_WORDS] = model_mem[(src_idx + i) % RAM_WORDS];
        end
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + r % (hi - lo + 1);
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        read_checks++;
        if (act !== exp) begin
            read_errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_done(input string name, input int exp, input int act);
        main_checks++;
        if (act != exp) begin
            main_errors++;
            $display("FAIL %s: expected %0d copy_done_o pulses, actual %0d", name, exp, act);
        end
    endtask

    task automatic issue_host(input logic we, input int idx, input word_t data, input mask_t mask);
        @(negedge clk);
        host_stb   = 1'b1;
        host_we    = we;
        host_addr  = word_t'(idx) << 2;
        host_wdata = data;
        host_mask  = mask;
        copy_stb   = 1'b0;
        if (we) begin
            model_mem[idx] = masked_write(model_mem[idx], data, mask);
        end else begin
            exp_q.push_back(model_mem[idx]);
            exp_name_q.push_back(cur_test);
        end
        last_idx = idx;
    endtask

    task automatic issue_copy(input int src_idx, input int dst_idx, input int len);
        @(negedge clk);
        copy_stb = 1'b1;
        copy_src = word_t'(src_idx) << 2;
        copy_dst = word_t'(dst_idx) << 2;
        copy_len = len_t'(len);
        host_stb = 1'b0;
        ref_copy(src_idx, dst_idx, len);
        copies_issued++;
    endtask

    task automatic release_strobes();
        @(negedge clk);
        host_stb = 1'b0;
        copy_stb = 1'b0;
    endtask

    task automatic wait_reads();
        int n;
        n = 0;
        release_strobes();
        do begin
            @(posedge clk);
            n++;
        end while (exp_q.size() != 0 && n < WAIT_LIMIT);
        if (exp_q.size() != 0) begin
            $display("ERROR %s: %0d host read responses never arrived", cur_test, exp_q.size());
            main_errors++;
            exp_q.delete();
            exp_name_q.delete();
        end
    endtask

    task automatic wait_copies();
        int n;
        n = 0;
        release_strobes();
        do begin
            @(posedge clk);
            n++;
        end while (done_count < copies_issued && n < WAIT_LIMIT);
        if (done_count < copies_issued) begin
            $display("ERROR %s: copy engine did not finish its descriptors in time", cur_test);
        end
        check_done(cur_test, copies_issued, done_count);
    endtask

    // at most three commands, then a read that drains the queue behind them
    task automatic host_op(input logic we, input int idx, input word_t data, input mask_t mask);
        issue_host(we, idx, data, mask);
        host_batch++;
        if (host_batch == 3) begin
            host_flush();
        end
    endtask

    task automatic host_flush();
        if (host_batch != 0) begin
            issue_host(1'b0, last_idx, '0, '0);
            wait_reads();
            host_batch = 0;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errs_at_start = read_errors + main_errors;
    endtask

    task automatic end_test();
        int errs;
        errs = read_errors + main_errors - errs_at_start;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, errs);
            tests_failed++;
        end
    endtask

    // read responses in issue order
    always @(negedge clk) begin
        if (!rst_i && host_rvalid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: host read response arrived with no read outstanding");
                read_errors++;
            end else begin
                check_word(exp_name_q.pop_front(), exp_q.pop_front(), host_rdata);
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_i && copy_done) begin
            done_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR: run stopped after %0d cycles waiting for the DUT", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        int idx_list [N_RAND];
        int len;
        int a_idx;
        int b_idx;
        seed = 32'hd328_7cd6;
        for (int i = 0; i < RAM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        rst_i      = 1'b1;
        host_stb   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        host_mask  = '0;
        copy_stb   = 1'b0;
        copy_src   = '0;
        copy_dst   = '0;
        copy_len   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        start_test("full_word");
        for (int i = 0; i < N_RAND; i++) begin
            idx_list[i] = rand_range(0, 127);
            host_op(1'b1, idx_list[i], word_t'($random(seed)), 4'hf);
        end
        host_flush();
        for (int i = 0; i < N_RAND; i++) begin
            host_op(1'b0, idx_list[i], '0, '0);
        end
        host_flush();
        end_test();

        start_test("byte_mask");
        for (int i = 0; i < N_RAND; i++) begin
            host_op(1'b1, idx_list[i], word_t'($random(seed)), mask_t'(rand_range(0, 15)));
        end
        host_flush();
        for (int i = 0; i < N_RAND; i++) begin
            host_op(1'b0, idx_list[i], '0, '0);
        end
        host_flush();
        end_test();

        // four strobes on consecutive cycles
        start_test("back_to_back");
        a_idx = rand_range(128, 191);
        b_idx = a_idx + 64;
        issue_host(1'b1, a_idx, word_t'($random(seed)), 4'hf);
        issue_host(1'b1, b_idx, word_t'($random(seed)), 4'b0101);
        issue_host(1'b0, b_idx, '0, '0);
        issue_host(1'b0, a_idx, '0, '0);
        wait_reads();
        end_test();

        start_test("block_copy");
        len = rand_range(8, MAX_LEN4);
        for (int i = 0; i < len; i++) begin
            host_op(1'b1, 256 + i, word_t'($random(seed)), 4'hf);
        end
        host_flush();
        issue_copy(256, 384, len);
        wait_copies();
        for (int i = 0; i < len; i++) begin
            host_op(1'b0, 384 + i, '0, '0);
        end
        for (int i = 0; i < len; i++) begin
            host_op(1'b0, 256 + i, '0, '0);
        end
        host_flush();
        end_test();

        // host region 0..127 stays clear of the copy regions
        start_test("concurrent");
        len = rand_range(24, MAX_LEN5);
        issue_copy(384, 640, len);
        for (int i = 0; i < 2 * N_RAND; i++) begin
            host_op(logic'(rand_range(0, 1)), rand_range(0, 127), word_t'($random(seed)),
                    mask_t'(rand_range(0, 15)));
        end
        host_flush();
        wait_copies();
        for (int i = 0; i < len; i++) begin
            host_op(1'b0, 640 + i, '0, '0);
        end
        host_flush();
        end_test();

        // source 512 is still clear while 640 holds copied data
        start_test("zero_length");
        issue_copy(512, 640, 0);
        wait_copies();
        for (int i = 0; i < N_ZERO; i++) begin
            host_op(1'b0, 640 + i, '0, '0);
        end
        host_flush();
        // no stray pulses since the last descriptor
        check_done(cur_test, copies_issued, done_count);
        end_test();

        $display("%0d checks, %0d errors, %0d of %0d tests failed",
                 read_checks + main_checks, read_errors + main_errors, tests_failed, tests_run);
        if (read_errors + main_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
src/sys_pkg.sv
src/system_ram.sv
src/cmd_fifo.sv
src/bus_arbiter.sv
src/host_port.sv
src/copy_engine.sv
src/mem_subsystem.sv
tb/tb_clock.sv
tb/tb_mem_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
